/* all.f */
hdl/oq_pkg.sv
hdl/fallthrough_fifo.sv
hdl/pkt_steer.sv
hdl/queue_store.sv
hdl/output_queues.sv
tb/tb_output_queues.sv

/* hdl/fallthrough_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fallthrough_fifo
// Small register FIFO of bus words; the head word
// shows at dout with no read delay. Flags for
// nearly full and a programmable fill level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module fallthrough_fifo #(
   parameter int DEPTH_BITS          = 3,
   parameter int PROG_FULL_THRESHOLD = 2
) (
   input  wire                   clk,
   input  wire                   reset,
   input  wire oq_pkg::oq_word_t din,
   input  wire                   wr_en,
   input  wire                   rd_en,
   output oq_pkg::oq_word_t      dout,
   output logic                  empty,
   output logic                  nearly_full,
   output logic                  prog_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   oq_pkg::oq_word_t      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   assign full  = count == (DEPTH_BITS+1)'(DEPTH);
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   assign dout        = mem[rd_ptr];   // fall-through head
   assign empty       = count == '0;
   assign nearly_full = count >= (DEPTH_BITS+1)'(DEPTH - 1);   // one slot left
   assign prog_full   = count >= (DEPTH_BITS+1)'(PROG_FULL_THRESHOLD);

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push and pop together
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/oq_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oq_pkg
// Shared types and constants of the output queues:
// the bus word, the IOQ header layout and the
// steering states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package oq_pkg;

   localparam int DATA_WIDTH = 64;
   localparam int CTRL_WIDTH = 8;

   // one bus word, ctrl in the top bits
   typedef struct packed {
      logic [CTRL_WIDTH-1:0] ctrl;
      logic [DATA_WIDTH-1:0] data;
   } oq_word_t;

   // ctrl 0 is a body word, anything else nonzero is a module header
   // before the IOQ header, or end-of-packet after a body word
   localparam logic [CTRL_WIDTH-1:0] IOQ_CTRL = 8'hFF;

   // IOQ header fields
   localparam int IOQ_DST_POS      = 48;   // destination port mask
   localparam int IOQ_WORD_LEN_POS = 32;   // body words, header not counted
   localparam int PKT_WORDS_WIDTH  = 10;

   typedef enum logic [1:0] {
      wait_ioq_hdr,
      check_space,
      store_pkt,
      drop_pkt
   } steer_state_t;

endpackage

`default_nettype wire

/* hdl/output_queues.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output_queues
// Packet output-queue block. Input FIFO, packet
// steering by IOQ header, and one queue per port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module output_queues #(
   parameter int NUM_QUEUES       = 4,
   parameter int QUEUE_ADDR_WIDTH = 6
) (
   input  wire                                   clk,
   input  wire                                   reset,
   input  wire oq_pkg::oq_word_t                 in_word,
   input  wire                                   in_wr,
   output logic                                  in_rdy,
   output oq_pkg::oq_word_t [NUM_QUEUES-1:0]     out_word,
   output logic [NUM_QUEUES-1:0]                 out_wr,
   input  wire [NUM_QUEUES-1:0]                  out_rdy
);

   localparam int IN_FIFO_DEPTH_BITS = 4;

   oq_pkg::oq_word_t                        fifo_word;
   logic                                    fifo_empty;
   logic                                    fifo_rd_en;
   logic                                    fifo_nearly_full;
   logic [NUM_QUEUES-1:0]                   wr_req;
   logic [NUM_QUEUES-1:0][QUEUE_ADDR_WIDTH:0] free_words;

   assign in_rdy = !fifo_nearly_full;

   fallthrough_fifo #(
      .DEPTH_BITS          (IN_FIFO_DEPTH_BITS),
      .PROG_FULL_THRESHOLD ((1 << IN_FIFO_DEPTH_BITS) - 2)
   ) in_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         (in_word),
      .wr_en       (in_wr),
      .rd_en       (fifo_rd_en),
      .dout        (fifo_word),
      .empty       (fifo_empty),
      .nearly_full (fifo_nearly_full),
      .prog_full   ()
   );

   pkt_steer #(
      .NUM_QUEUES       (NUM_QUEUES),
      .QUEUE_ADDR_WIDTH (QUEUE_ADDR_WIDTH)
   ) steer (
      .clk        (clk),
      .reset      (reset),
      .fifo_word  (fifo_word),
      .fifo_empty (fifo_empty),
      .fifo_rd_en (fifo_rd_en),
      .free_words (free_words),
      .wr_req     (wr_req)
   );

   // every queue sees the FIFO head, only its wr_req decides
   for (genvar i = 0; i < NUM_QUEUES; i++) begin : gen_queues
      queue_store #(
         .QUEUE_ADDR_WIDTH (QUEUE_ADDR_WIDTH)
      ) queue (
         .clk        (clk),
         .reset      (reset),
         .wr_req     (wr_req[i]),
         .wr_word    (fifo_word),
         .free_words (free_words[i]),
         .out_word   (out_word[i]),
         .out_wr     (out_wr[i]),
         .out_rdy    (out_rdy[i])
      );
   end

endmodule

`default_nettype wire

/* hdl/pkt_steer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pkt_steer
// Pops packets from the input FIFO, strips module
// headers, checks queue space at the IOQ header and
// writes each packet to every queue with room, or
// drops it whole
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module pkt_steer #(
   parameter int NUM_QUEUES       = 4,
   parameter int QUEUE_ADDR_WIDTH = 6
) (
   input  wire                                        clk,
   input  wire                                        reset,
   input  wire oq_pkg::oq_word_t                      fifo_word,
   input  wire                                        fifo_empty,
   output logic                                       fifo_rd_en,
   input  wire [NUM_QUEUES-1:0][QUEUE_ADDR_WIDTH:0]   free_words,
   output logic [NUM_QUEUES-1:0]                      wr_req
);

   localparam int LEN_WIDTH = oq_pkg::PKT_WORDS_WIDTH + 1;   // room for the +1

   oq_pkg::steer_state_t                 state;
   oq_pkg::steer_state_t                 state_nxt;

   logic [NUM_QUEUES-1:0]                dst_mask;     // queues still targeted
   logic [LEN_WIDTH-1:0]                 pkt_words;    // body plus IOQ header
   logic [NUM_QUEUES-1:0][QUEUE_ADDR_WIDTH:0] free_snap;
   logic [NUM_QUEUES-1:0]                space_ok;
   logic [NUM_QUEUES-1:0]                hdr_dst;
   logic [oq_pkg::PKT_WORDS_WIDTH-1:0]   hdr_len;
   logic                                 is_ioq_hdr;
   logic                                 is_body;
   logic                                 is_eop;
   logic                                 prev_body;    // last popped word had ctrl 0
   logic                                 latch_hdr;

   // header field pickup
   assign hdr_dst = fifo_word.data[oq_pkg::IOQ_DST_POS +: NUM_QUEUES];
   assign hdr_len = fifo_word.data[oq_pkg::IOQ_WORD_LEN_POS +: oq_pkg::PKT_WORDS_WIDTH];

   assign is_ioq_hdr = fifo_word.ctrl == oq_pkg::IOQ_CTRL;
   assign is_body    = fifo_word.ctrl == '0;
   assign is_eop     = !is_body && prev_body;   // same rule on store and drop path

   // a queue takes the packet only with strictly more room than it needs
   always_comb begin
      for (int i = 0; i < NUM_QUEUES; i++) begin
         space_ok[i] = free_snap[i] > pkt_words;
      end
   end

   always_comb begin
      state_nxt  = state;
      fifo_rd_en = 1'b0;
      wr_req     = '0;
      latch_hdr  = 1'b0;

      case (state)
         oq_pkg::wait_ioq_hdr: begin
            if (!fifo_empty) begin
               if (is_ioq_hdr) begin
                  latch_hdr = 1'b1;   // header stays at the head for storing
                  state_nxt = oq_pkg::check_space;
               end else begin
                  fifo_rd_en = 1'b1;  // module header, thrown away
               end
            end
         end

         oq_pkg::check_space: begin
            if ((dst_mask & space_ok) == '0) begin
               state_nxt = oq_pkg::drop_pkt;
            end else begin
               state_nxt = oq_pkg::store_pkt;
            end
         end

         oq_pkg::store_pkt: begin
            if (!fifo_empty) begin
               fifo_rd_en = 1'b1;
               wr_req     = dst_mask;   // queues never stall a write
               if (is_eop) begin
                  state_nxt = oq_pkg::wait_ioq_hdr;
               end
            end
         end

         oq_pkg::drop_pkt: begin
            if (!fifo_empty) begin
               fifo_rd_en = 1'b1;
               if (is_eop) begin
                  state_nxt = oq_pkg::wait_ioq_hdr;
               end
            end
         end

         default: state_nxt = oq_pkg::wait_ioq_hdr;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= oq_pkg::wait_ioq_hdr;
         prev_body <= 1'b0;
      end else begin
         state <= state_nxt;
         if (latch_hdr) begin
            prev_body <= 1'b0;   // the header itself must not end the packet
         end else if (fifo_rd_en) begin
            prev_body <= is_body;
         end
      end
   end

   // per-packet values, only read after a header was latched
   always_ff @(posedge clk) begin
      if (latch_hdr) begin
         dst_mask  <= hdr_dst;
         pkt_words <= {1'b0, hdr_len} + LEN_WIDTH'(1);
         free_snap <= free_words;
      end else if (state == oq_pkg::check_space) begin
         dst_mask <= dst_mask & space_ok;   // drop from the full queues
      end
   end

endmodule

`default_nettype wire

/* hdl/queue_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// queue_store
// One output queue. Ring memory of bus words, read
// ahead into a small buffer that covers the delay
// of the port's ready level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module queue_store #(
   parameter int QUEUE_ADDR_WIDTH = 6
) (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        wr_req,
   input  wire oq_pkg::oq_word_t      wr_word,
   output logic [QUEUE_ADDR_WIDTH:0]  free_words,
   output oq_pkg::oq_word_t           out_word,
   output logic                       out_wr,
   input  wire                        out_rdy
);

   localparam int QUEUE_WORDS    = 1 << QUEUE_ADDR_WIDTH;
   localparam int BUF_DEPTH_BITS = 3;
   localparam int BUF_PROG_FULL  = 2;   // leaves room for reads in flight

   oq_pkg::oq_word_t              mem [QUEUE_WORDS];
   logic [QUEUE_ADDR_WIDTH-1:0]   wr_ptr;
   logic [QUEUE_ADDR_WIDTH-1:0]   rd_ptr;
   logic [QUEUE_ADDR_WIDTH:0]     mem_count;   // words not yet read from memory
   logic [QUEUE_ADDR_WIDTH:0]     occupancy;   // memory, read stage and buffer
   logic                          rd_req;
   logic                          rd_vld;
   oq_pkg::oq_word_t              rd_word;
   logic                          buf_empty;
   logic                          buf_prog_full;

   // read ahead only while the buffer is low
   assign rd_req = (mem_count != '0) && !buf_prog_full;

   assign free_words = (QUEUE_ADDR_WIDTH+1)'(QUEUE_WORDS) - occupancy;
   assign out_wr     = out_rdy && !buf_empty;

   // ring memory, one cycle read
   always_ff @(posedge clk) begin
      if (wr_req) begin
         mem[wr_ptr] <= wr_word;
      end
      if (rd_req) begin
         rd_word <= mem[rd_ptr];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         mem_count <= '0;
         occupancy <= '0;
         rd_vld    <= 1'b0;
      end else begin
         rd_vld <= rd_req;
         if (wr_req) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_req) begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         case ({wr_req, rd_req})
            2'b10:   mem_count <= mem_count + 1'b1;
            2'b01:   mem_count <= mem_count - 1'b1;
            default: mem_count <= mem_count;
         endcase

         // space comes back only when a word leaves the port
         case ({wr_req, out_wr})
            2'b10:   occupancy <= occupancy + 1'b1;
            2'b01:   occupancy <= occupancy - 1'b1;
            default: occupancy <= occupancy;
         endcase
      end
   end

   fallthrough_fifo #(
      .DEPTH_BITS          (BUF_DEPTH_BITS),
      .PROG_FULL_THRESHOLD (BUF_PROG_FULL)
   ) out_buf (
      .clk         (clk),
      .reset       (reset),
      .din         (rd_word),
      .wr_en       (rd_vld),
      .rd_en       (out_wr),
      .dout        (out_word),
      .empty       (buf_empty),
      .nearly_full (),
      .prog_full   (buf_prog_full)
   );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the output queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_output_queues \
   -o tb_output_queues
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_output_queues > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Everything OK" "$LOG"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

/* tb/oq_vectors.txt */
// columns, all hex: test, ready mask, module headers, destination mask,
// body words, expected store mask; ready bit 4 set means ready follows LFSR bits
// queues hold 64 words, a packet is stored only while free > body + 1
01 0f 02 01 08 01
01 0f 02 04 05 04
02 0f 00 0f 06 0f
02 0f 01 0a 0c 0a
02 0f 00 05 03 05
03 0e 00 01 0e 01
03 0e 00 01 0e 01
03 0e 00 01 0e 01
03 0e 00 01 0e 01
03 0e 00 01 0e 00
03 0e 00 01 03 00
03 0e 00 01 02 01
03 0e 00 02 04 02
04 0e 00 03 05 02
04 0e 01 01 02 00
04 0e 00 08 06 08
05 0f 00 04 04 04
06 0f 00 01 0a 01
06 0f 02 0f 04 0f
07 1f 01 0f 0a 0f
07 1f 00 03 07 03
07 1f 02 0c 09 0c
07 1f 00 05 0d 05
07 1f 01 0a 05 0a
07 1f 00 0f 03 0f
07 1f 00 09 08 09
07 1f 03 06 06 06
08 1f 00 0f 0e 0f
08 1f 01 01 1e 01
08 1f 00 0e 10 0e
08 1f 02 02 0c 02
08 1f 00 0c 08 0c
08 1f 00 0b 02 0b
08 1f 01 04 0f 04

/* tb/tb_output_queues.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_output_queues
// Testbench of the output queues. Reads packet
// commands from a vector file, drives them in and
// checks every port against its expected word list
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_output_queues;

   localparam int NUM_QUEUES       = 4;
   localparam int QUEUE_ADDR_WIDTH = 6;
   localparam int VEC_MAX          = 64;     // command lines
   localparam int EXP_DEPTH        = 1024;   // expected words per port
   localparam logic [31:0] SEED    = 32'd77525;

   logic                                  clk;
   logic                                  reset;
   oq_pkg::oq_word_t                      in_word;
   logic                                  in_wr;
   logic                                  in_rdy;
   oq_pkg::oq_word_t [NUM_QUEUES-1:0]     out_word;
   logic [NUM_QUEUES-1:0]                 out_wr;
   logic [NUM_QUEUES-1:0]                 out_rdy;

   logic [15:0]       vec_mem [VEC_MAX*6];
   oq_pkg::oq_word_t  exp_mem [NUM_QUEUES][EXP_DEPTH];
   int                exp_wr [NUM_QUEUES];
   int                exp_rd [NUM_QUEUES];
   logic [31:0]       lfsr_state;
   logic [NUM_QUEUES-1:0] rdy_mask;
   logic              rdy_random;   // ready levels from LFSR bits
   int                errors = 0;
   int                tests = 0;
   int                packets = 0;
   int                words_checked = 0;
   int                watchdog_cycles = 0;

   output_queues #(
      .NUM_QUEUES       (NUM_QUEUES),
      .QUEUE_ADDR_WIDTH (QUEUE_ADDR_WIDTH)
   ) dut (
      .clk      (clk),
      .reset    (reset),
      .in_word  (in_word),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .out_word (out_word),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois, right shift
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[62:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   // every input change goes through here, on the falling edge
   task automatic step_cycle();
      logic [63:0] r;
      @(negedge clk);
      if (rdy_random) begin
         r = rand_bits(NUM_QUEUES);
         out_rdy = r[NUM_QUEUES-1:0];
      end else begin
         out_rdy = rdy_mask;
      end
   endtask

   task automatic push_word(input oq_pkg::oq_word_t w);
      step_cycle();
      in_wr = 1'b0;
      while (!in_rdy) begin
         step_cycle();
      end
      in_word = w;
      in_wr   = 1'b1;
   endtask

   function automatic void add_expected(input logic [15:0] mask, input oq_pkg::oq_word_t w);
      int p;
      for (p = 0; p < NUM_QUEUES; p++) begin
         if (mask[p]) begin
            exp_mem[p][exp_wr[p]] = w;
            exp_wr[p]++;
         end
      end
   endfunction

   task automatic send_packet(input logic [15:0] n_mhdr, input logic [15:0] dst,
                              input logic [15:0] len, input logic [15:0] store_mask);
      oq_pkg::oq_word_t w;
      int i;
      for (i = 0; i < int'(n_mhdr); i++) begin
         w.ctrl = 8'h10 + 8'(i);   // module header, stripped by the DUT
         w.data = rand_bits(64);
         push_word(w);
      end
      w.ctrl = oq_pkg::IOQ_CTRL;
      w.data = (64'(dst) << oq_pkg::IOQ_DST_POS) | (64'(len) << oq_pkg::IOQ_WORD_LEN_POS)
             | 64'(packets);
      add_expected(store_mask, w);
      push_word(w);
      for (i = 0; i < int'(len); i++) begin
         w.ctrl = (i == int'(len) - 1) ? 8'h01 : 8'h00;   // last body word ends it
         w.data = rand_bits(64);
         add_expected(store_mask, w);
         push_word(w);
      end
      packets++;
   endtask

   // ports held not ready keep their words
   function automatic logic all_drained();
      int p;
      all_drained = 1'b1;
      for (p = 0; p < NUM_QUEUES; p++) begin
         if ((rdy_random || rdy_mask[p]) && exp_rd[p] != exp_wr[p]) begin
            all_drained = 1'b0;
         end
      end
   endfunction

   task automatic end_test(input int num, input int err_start);
      do begin
         step_cycle();
         in_wr = 1'b0;
      end while (!all_drained());
      if (errors == err_start) begin
         $display("test %0d finished: ok", num);
      end else begin
         $display("test %0d finished: %0d errors", num, errors - err_start);
      end
      tests++;
   endtask

   always @(posedge clk) begin : port_monitor
      int p;
      if (!reset) begin
         for (p = 0; p < NUM_QUEUES; p++) begin
            if (out_wr[p] && exp_rd[p] == exp_wr[p]) begin
               $display("%0t: port %0d sent word %h with nothing expected", $time, p,
                        out_word[p]);
               errors++;
            end else if (out_wr[p]) begin
               if (out_word[p] !== exp_mem[p][exp_rd[p]]) begin
                  $display("ERROR %0t out_word[%0d] expected %h got %h", $time, p,
                           exp_mem[p][exp_rd[p]], out_word[p]);
                  errors++;
               end
               exp_rd[p]++;
               words_checked++;
            end
         end
      end
   end

   initial begin : watchdog
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: run still busy after %0d cycles", watchdog_cycles);
      $display("Something failed");
      $finish;
   end

   initial begin : main
      int k;
      int n_vec;
      int body_total;
      int cur_test;
      int err_start;
      logic [15:0] f [6];
      reset      = 1'b1;
      in_word    = '0;
      in_wr      = 1'b0;
      out_rdy    = '0;
      rdy_mask   = '0;
      rdy_random = 1'b0;
      lfsr_state = SEED;
      for (k = 0; k < NUM_QUEUES; k++) begin
         exp_wr[k] = 0;
         exp_rd[k] = 0;
      end
      for (k = 0; k < VEC_MAX*6; k++) begin
         vec_mem[k] = 16'hFFFF;   // end marker
      end
      $readmemh("tb/oq_vectors.txt", vec_mem);
      n_vec      = 0;
      body_total = 0;
      while (n_vec < VEC_MAX && vec_mem[n_vec*6] != 16'hFFFF) begin
         body_total += int'(vec_mem[n_vec*6+4]);
         n_vec++;
      end
      watchdog_cycles = 200 * body_total + 2000;
      if (n_vec == 0) begin
         $display("no test commands could be read from the vector file");
         errors++;
      end

      repeat (2) @(posedge clk);
      @(negedge clk);
      reset    = 1'b0;
      cur_test = -1;
      err_start = 0;
      for (k = 0; k < n_vec; k++) begin
         for (int j = 0; j < 6; j++) begin
            f[j] = vec_mem[k*6+j];
         end
         if (int'(f[0]) != cur_test) begin
            if (cur_test >= 0) begin
               end_test(cur_test, err_start);
            end
            cur_test   = int'(f[0]);
            err_start  = errors;
            rdy_random = f[1][NUM_QUEUES];
            rdy_mask   = f[1][NUM_QUEUES-1:0];
         end
         send_packet(f[2], f[3], f[4], f[5]);
      end
      if (cur_test >= 0) begin
         end_test(cur_test, err_start);
      end

      // idle state once everything has left
      rdy_random = 1'b0;
      rdy_mask   = '1;
      step_cycle();
      @(posedge clk);
      if (in_rdy !== 1'b1) begin
         $display("ERROR %0t in_rdy expected 1 got %b", $time, in_rdy);
         errors++;
      end
      if (out_wr !== '0) begin
         $display("ERROR %0t out_wr expected %b got %b", $time, {NUM_QUEUES{1'b0}}, out_wr);
         errors++;
      end

      $display("%0d tests, %0d packets, %0d words checked, %0d errors",
               tests, packets, words_checked, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
